/* build.f */
+incdir+design
design/z80_pkg.sv
design/z80_decode.sv
design/z80_exec.sv
design/z80_io_port.sv
design/z80_core_top.sv
test/z80_checker.sv
test/z80_core_tb.sv

/* Makefile */
# Verilator build and run of the Z80 subset core testbench

VERILATOR ?= verilator
TOP       ?= z80_core_tb
RTL_TOP   ?= z80_core_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/z80_core_tb.sv */
/* Each program runs twice, first with zero ack delay, then with random
   delays of 0 to 3 cycles. Programs are 12 bytes placed at the reset PC */
`timescale 1ns/1ps
`default_nettype none
`include "z80_settings.svh"

module z80_core_tb;

        localparam int NUM_TESTS  = 13;
        localparam int NUM_PASSES = 2;
        // Cycle budget of one program run
        localparam int RUN_CYCLES = 400;
        localparam int CLK_PERIOD = 20;

        // One table row, program byte 0 in the top byte
        typedef struct packed {
                logic [95:0]    name;
                logic [95:0]    prog;
                z80_pkg::byte_t port_val;
                z80_pkg::addr_t exp_adr;
                z80_pkg::byte_t exp_dat;
                z80_pkg::byte_t exp_port;
        } test_row_t;

        logic           clk;
        logic           arst_n;
        logic           wb_cyc;
        logic           wb_stb;
        logic           wb_we;
        logic           wb_ack;
        z80_pkg::addr_t wb_adr;
        z80_pkg::byte_t wb_dat_wr;
        z80_pkg::byte_t wb_dat_rd;
        z80_pkg::byte_t port_in;
        z80_pkg::byte_t port_out;
        logic           halt;
        z80_pkg::byte_t mem [65536];
        test_row_t      tests [NUM_TESTS];
        test_row_t      cur;
        integer         seed;
        int             delay_mask;
        int             wait_cnt;
        logic           start;
        logic           done;
        int             mismatch_cnt;
        int             fault_cnt;

        z80_core_top dut_i (
                .wb_clk_i (clk),
                .arst_n_i (arst_n),
                .wb_dat_i (wb_dat_rd),
                .wb_ack_i (wb_ack),
                .port_i   (port_in),
                .wb_cyc_o (wb_cyc),
                .wb_stb_o (wb_stb),
                .wb_we_o  (wb_we),
                .wb_adr_o (wb_adr),
                .wb_dat_o (wb_dat_wr),
                .port_o   (port_out),
                .halt_o   (halt)
        );

        z80_checker checker_i (
                .clk_i          (clk),
                .wb_cyc_i       (wb_cyc),
                .wb_stb_i       (wb_stb),
                .wb_we_i        (wb_we),
                .wb_ack_i       (wb_ack),
                .wb_adr_i       (wb_adr),
                .wr_dat_i       (wb_dat_wr),
                .port_i         (port_out),
                .halt_i         (halt),
                .name_i         (cur.name),
                .exp_adr_i      (cur.exp_adr),
                .exp_dat_i      (cur.exp_dat),
                .exp_port_i     (cur.exp_port),
                .start_i        (start),
                .done_i         (done),
                .mismatch_cnt_o (mismatch_cnt),
                .fault_cnt_o    (fault_cnt)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // Background contents, every address bit takes part
        function automatic z80_pkg::byte_t fill_byte(input z80_pkg::addr_t a);
                return a[15:8] ^ a[7:0] ^ 8'h5A;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Program table, unused tail bytes are HALT
        ////////////////////////////////////////////////////////////////////////////

        task automatic load_table();
                // LD C,3C; LD E,C; LD H,E; LD L,H; LD A,L; LD (0100),A
                tests[0]  = '{"ld_moves", 96'h0E3C_5963_6C7D_3200_0176_7676,
                              8'h00, 16'h0100, 8'h3C, 8'h00};
                // LD A,F0; LD B,25; ADD B; LD (0101),A
                tests[1]  = '{"add_wrap", 96'h3EF0_0625_8032_0101_7676_7676,
                              8'h00, 16'h0101, 8'hF0 + 8'h25, 8'h00};
                // LD A,80; ADD 80; LD (0102),A
                tests[2]  = '{"add_imm", 96'h3E80_C680_3202_0176_7676_7676,
                              8'h00, 16'h0102, 8'h80 + 8'h80, 8'h00};
                // LD A,10; LD D,30; SUB D; LD (0103),A
                tests[3]  = '{"sub_borrow", 96'h3E10_1630_9232_0301_7676_7676,
                              8'h00, 16'h0103, 8'h10 - 8'h30, 8'h00};
                // LD A,CA; AND 0F; XOR 55; OR 80; LD (0104),A
                tests[4]  = '{"logic_imm", 96'h3ECA_E60F_EE55_F680_3204_0176,
                              8'h00, 16'h0104, ((8'hCA & 8'h0F) ^ 8'h55) | 8'h80, 8'h00};
                // LD A,F0; LD H,3C; AND H; LD L,0F; OR L; LD (0105),A
                tests[5]  = '{"logic_reg", 96'h3EF0_263C_A42E_0FB5_3205_0176,
                              8'h00, 16'h0105, (8'hF0 & 8'h3C) | 8'h0F, 8'h00};
                // A is 00 after reset, so CP 00 sets Z and CP 05 sets C
                // CP n; JP cc,0007; LD A,11; at 0007 LD (0106),A
                tests[6]  = '{"cp_jz_take", 96'hFE00_CA07_003E_1132_0601_7676,
                              8'h00, 16'h0106, 8'h00, 8'h00};
                tests[7]  = '{"cp_jz_fall", 96'hFE05_CA07_003E_1132_0601_7676,
                              8'h00, 16'h0106, 8'h11, 8'h00};
                tests[8]  = '{"cp_jc_take", 96'hFE05_DA07_003E_1132_0601_7676,
                              8'h00, 16'h0106, 8'h00, 8'h00};
                tests[9]  = '{"cp_jc_fall", 96'hFE00_DA07_003E_1132_0601_7676,
                              8'h00, 16'h0106, 8'h11, 8'h00};
                // LD A,(1234); LD (0107),A
                tests[10] = '{"mem_copy", 96'h3A34_1232_0701_7676_7676_7676,
                              8'h00, 16'h0107, fill_byte(16'h1234), 8'h00};
                // IN A,(20); OUT (21),A; LD (0108),A
                tests[11] = '{"port_echo", 96'hDB20_D321_3208_0176_7676_7676,
                              8'hA5, 16'h0108, 8'hA5, 8'hA5};
                // LD A,77; INC A and LD A,(HL) as NOP; store; HALT; store
                tests[12] = '{"halt_nop", 96'h3E77_3C7E_3209_0176_320A_0176,
                              8'h00, 16'h0109, 8'h77, 8'h00};
        endtask

        task automatic load_memory(input logic [95:0] prog);
                for (int a = 0; a < 65536; a++)
                        mem[a] = fill_byte(16'(a));
                for (int i = 0; i < 12; i++)
                        mem[`Z80_RESET_PC + i] = prog[95 - 8 * i -: 8];
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Byte memory, four-phase slave
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk) begin
                if (!arst_n) begin
                        wb_ack   = 1'b0;
                        wait_cnt = $random(seed) & delay_mask;
                end else if (wb_cyc && wb_stb && !wb_ack) begin
                        // Answer once the drawn wait has run out
                        if (wait_cnt == 0) begin
                                wb_ack    = 1'b1;
                                wb_dat_rd = mem[wb_adr];
                                if (wb_we)
                                        mem[wb_adr] = wb_dat_wr;
                        end else begin
                                wait_cnt = wait_cnt - 1;
                        end
                end else if (!wb_stb && wb_ack) begin
                        wb_ack   = 1'b0;
                        wait_cnt = $random(seed) & delay_mask;
                end
        end

        task automatic run_test(input test_row_t row);
                @(negedge clk);
                arst_n  = 1'b0;
                cur     = row;
                port_in = row.port_val;
                load_memory(row.prog);
                start   = 1'b1;
                @(negedge clk);
                start   = 1'b0;
                repeat (2) @(negedge clk);
                arst_n  = 1'b1;
                while (!halt)
                        @(negedge clk);
                // Window for a stray store after HALT
                repeat (4) @(negedge clk);
                done = 1'b1;
                @(negedge clk);
                done = 1'b0;
        endtask

        initial begin
                seed       = 64;
                clk        = 1'b0;
                arst_n     = 1'b0;
                wb_ack     = 1'b0;
                wb_dat_rd  = 8'h00;
                port_in    = 8'h00;
                start      = 1'b0;
                done       = 1'b0;
                delay_mask = 0;
                wait_cnt   = 0;
                cur        = '0;
                load_table();
                for (int pass = 0; pass < NUM_PASSES; pass++) begin
                        delay_mask = (pass == 0) ? 0 : 3;
                        $display("pass %0d, ack delay up to %0d cycles", pass, delay_mask);
                        for (int t = 0; t < NUM_TESTS; t++)
                                run_test(tests[t]);
                end
                $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
                if (mismatch_cnt == 0 && fault_cnt == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

        // Watchdog
        initial begin
                #(NUM_TESTS * NUM_PASSES * RUN_CYCLES * CLK_PERIOD);
                $display("watchdog expired, a program never reached HALT");
                $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fault_cnt);
                $display("=== FAIL ===");
                $finish;
        end

endmodule

`default_nettype wire

/* test/z80_checker.sv */
/* Watches bus writes, port_o and halt_o of one program run.
   Every program is expected to store exactly one byte */
`timescale 1ns/1ps
`default_nettype none

module z80_checker (
        input  wire logic            clk_i,
        input  wire logic            wb_cyc_i,
        input  wire logic            wb_stb_i,
        input  wire logic            wb_we_i,
        input  wire logic            wb_ack_i,
        input  wire z80_pkg::addr_t  wb_adr_i,
        input  wire z80_pkg::byte_t  wr_dat_i,
        input  wire z80_pkg::byte_t  port_i,
        input  wire logic            halt_i,
        input  wire logic [95:0]     name_i,
        input  wire z80_pkg::addr_t  exp_adr_i,
        input  wire z80_pkg::byte_t  exp_dat_i,
        input  wire z80_pkg::byte_t  exp_port_i,
        input  wire logic            start_i,
        input  wire logic            done_i,
        output int                   mismatch_cnt_o,
        output int                   fault_cnt_o
);

        int             mismatch_cnt = 0;
        int             fault_cnt = 0;
        int             wr_cnt = 0;
        z80_pkg::addr_t wr_adr;
        z80_pkg::byte_t wr_dat;
        logic           wr_seen;

        // A write completes on the one edge where stb and ack meet
        assign wr_seen        = wb_stb_i && wb_we_i && wb_ack_i;
        assign mismatch_cnt_o = mismatch_cnt;
        assign fault_cnt_o    = fault_cnt;

        // End of run, compare against the table row
        task automatic compare_run();
                if (wr_cnt == 0) begin
                        fault_cnt++;
                        $display("%s: expected store to %h never appeared", name_i, exp_adr_i);
                end else begin
                        if (wr_cnt > 1) begin
                                fault_cnt++;
                                $display("%s: %0d bus writes seen, one expected", name_i, wr_cnt);
                        end
                        if (wr_adr !== exp_adr_i) begin
                                mismatch_cnt++;
                                $display("mismatch %s store address expected %h actual %h",
                                         name_i, exp_adr_i, wr_adr);
                        end
                        if (wr_dat !== exp_dat_i) begin
                                mismatch_cnt++;
                                $display("mismatch %s store data expected %h actual %h",
                                         name_i, exp_dat_i, wr_dat);
                        end
                end
                if (port_i !== exp_port_i) begin
                        mismatch_cnt++;
                        $display("mismatch %s port_o expected %h actual %h",
                                 name_i, exp_port_i, port_i);
                end
                if (halt_i !== 1'b1) begin
                        fault_cnt++;
                        $display("%s: halt_o dropped before the end of the run", name_i);
                end
        endtask

        always @(posedge clk_i) begin
                if (start_i) begin
                        wr_cnt = 0;
                end else begin
                        // A strobe is only valid inside a bus cycle
                        if (wb_stb_i && !wb_cyc_i) begin
                                fault_cnt++;
                                $display("%s: bus strobe raised without cycle", name_i);
                        end
                        if (wr_seen) begin
                                if (halt_i) begin
                                        fault_cnt++;
                                        $display("%s: bus write to %h after HALT",
                                                 name_i, wb_adr_i);
                                end
                                wr_cnt++;
                                wr_adr = wb_adr_i;
                                wr_dat = wr_dat_i;
                        end
                        if (done_i)
                                compare_run();
                end
        end

endmodule

`default_nettype wire

/* design/z80_core_top.sv */
/* Core top. Memory on a four-phase cyc/stb/ack byte bus,
   one 8-bit input port and one 8-bit output port */
`timescale 1ns/1ps
`default_nettype none

module z80_core_top (
        input  wire logic            wb_clk_i,
        input  wire logic            arst_n_i,
        input  wire z80_pkg::byte_t  wb_dat_i,
        input  wire logic            wb_ack_i,
        input  wire z80_pkg::byte_t  port_i,
        output logic                 wb_cyc_o,
        output logic                 wb_stb_o,
        output logic                 wb_we_o,
        output z80_pkg::addr_t       wb_adr_o,
        output z80_pkg::byte_t       wb_dat_o,
        output z80_pkg::byte_t       port_o,
        output logic                 halt_o
);

        z80_pkg::bus_req_t  bus;
        z80_pkg::exec_op_t  op;
        z80_pkg::exec_res_t res;
        z80_pkg::byte_t     rd_dat;
        logic               issue;
        logic               io_rd;
        logic               io_wr;

        ////////////////////////////////////////////////////////////////////////////
        // Sequencer, execute and port blocks
        ////////////////////////////////////////////////////////////////////////////

        z80_decode decode_i (
                .wb_clk_i (wb_clk_i),
                .arst_n_i (arst_n_i),
                .rd_dat_i (rd_dat),
                .wb_ack_i (wb_ack_i),
                .res_i    (res),
                .bus_o    (bus),
                .op_o     (op),
                .issue_o  (issue),
                .io_rd_o  (io_rd),
                .io_wr_o  (io_wr),
                .halt_o   (halt_o)
        );

        z80_exec exec_i (
                .wb_clk_i (wb_clk_i),
                .arst_n_i (arst_n_i),
                .op_i     (op),
                .issue_i  (issue),
                .res_o    (res)
        );

        // Also writes A to the output port
        z80_io_port io_port_i (
                .wb_clk_i (wb_clk_i),
                .arst_n_i (arst_n_i),
                .wb_dat_i (wb_dat_i),
                .port_i   (port_i),
                .io_rd_i  (io_rd),
                .io_wr_i  (io_wr),
                .a_val_i  (res.a_val),
                .rd_dat_o (rd_dat),
                .port_o   (port_o)
        );

        // Bus request onto the pins
        assign wb_cyc_o = bus.cyc;
        assign wb_stb_o = bus.stb;
        assign wb_we_o  = bus.we;
        assign wb_adr_o = bus.adr;
        assign wb_dat_o = bus.dat;

endmodule

`default_nettype wire

/* design/z80_io_port.sv */
/* Output port latch and read data routing. Port traffic never
   reaches the external bus */
`timescale 1ns/1ps
`default_nettype none

module z80_io_port (
        input  wire logic            wb_clk_i,
        input  wire logic            arst_n_i,
        input  wire z80_pkg::byte_t  wb_dat_i,
        input  wire z80_pkg::byte_t  port_i,
        input  wire logic            io_rd_i,
        input  wire logic            io_wr_i,
        input  wire z80_pkg::byte_t  a_val_i,
        output z80_pkg::byte_t       rd_dat_o,
        output z80_pkg::byte_t       port_o
);

        // OUT takes A on the edge after the strobe
        always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
                if (!arst_n_i)
                        port_o <= 8'h00;
                else if (io_wr_i)
                        port_o <= a_val_i;
        end

        // Port value only during the IN cycle, bus data otherwise
        assign rd_dat_o = io_rd_i ? port_i : wb_dat_i;

        // Decode never runs IN and OUT in the same cycle
        assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
                !(io_rd_i && io_wr_i));

endmodule

`default_nettype wire

/* design/z80_exec.sv */
/* Registers, ALU and Z/C flags. One operation per issue pulse,
   result visible the cycle after. Slot 6 of the file is never written */
`timescale 1ns/1ps
`default_nettype none
`include "z80_settings.svh"

module z80_exec (
        input  wire logic               wb_clk_i,
        input  wire logic               arst_n_i,
        input  wire z80_pkg::exec_op_t  op_i,
        input  wire logic               issue_i,
        output z80_pkg::exec_res_t      res_o
);

        z80_pkg::byte_t rf_q [8];
        logic           zf_q;
        logic           cf_q;
        z80_pkg::byte_t a_val;
        z80_pkg::byte_t opnd;
        z80_pkg::byte_t result;
        logic [8:0]     sum9;
        logic           carry;
        logic           upd_flags;

        assign a_val = rf_q[`Z80_REG_A];

        ////////////////////////////////////////////////////////////////////////////
        // ALU
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                opnd   = op_i.use_imm ? op_i.imm : rf_q[op_i.src];
                sum9   = 9'd0;
                result = opnd;
                carry  = cf_q;
                case (op_i.alu_op)
                z80_pkg::ALU_ADD: begin
                        sum9   = {1'b0, a_val} + {1'b0, opnd};
                        result = sum9[7:0];
                        carry  = sum9[8];
                end
                // Bit 8 of the difference is the borrow
                z80_pkg::ALU_SUB, z80_pkg::ALU_CP: begin
                        sum9   = {1'b0, a_val} - {1'b0, opnd};
                        result = sum9[7:0];
                        carry  = sum9[8];
                end
                z80_pkg::ALU_AND: begin
                        result = a_val & opnd;
                        carry  = 1'b0;
                end
                z80_pkg::ALU_XOR: begin
                        result = a_val ^ opnd;
                        carry  = 1'b0;
                end
                z80_pkg::ALU_OR: begin
                        result = a_val | opnd;
                        carry  = 1'b0;
                end
                // LOAD passes the operand through
                default: ;
                endcase
        end

        // Loads and idle ops keep the flags
        assign upd_flags = op_i.alu_op != z80_pkg::ALU_LOAD && op_i.alu_op != z80_pkg::ALU_NONE;

        always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        for (int i = 0; i < 8; i++)
                                rf_q[i] <= 8'h00;
                        zf_q <= 1'b0;
                        cf_q <= 1'b0;
                end else if (issue_i) begin
                        if (op_i.wr_dst)
                                rf_q[op_i.dst] <= result;
                        if (upd_flags) begin
                                zf_q <= result == 8'h00;
                                cf_q <= carry;
                        end
                end
        end

        assign res_o = '{a_val: a_val, zf: zf_q, cf: cf_q};

        // Every instruction has at least one bus byte between issues
        assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
                issue_i |=> !issue_i);

endmodule

`default_nettype wire

/* design/z80_decode.sv */
/* One four-phase bus cycle per byte. A new strobe waits for ack low.
   Opcodes outside the subset and (HL) forms run as NOP */
`timescale 1ns/1ps
`default_nettype none
`include "z80_settings.svh"

module z80_decode (
        input  wire logic                wb_clk_i,
        input  wire logic                arst_n_i,
        input  wire z80_pkg::byte_t      rd_dat_i,
        input  wire logic                wb_ack_i,
        input  wire z80_pkg::exec_res_t  res_i,
        output z80_pkg::bus_req_t        bus_o,
        output z80_pkg::exec_op_t        op_o,
        output logic                     issue_o,
        output logic                     io_rd_o,
        output logic                     io_wr_o,
        output logic                     halt_o
);

        z80_pkg::dec_state_e state_q;
        z80_pkg::addr_t      pc_q;
        logic                stb_q;
        z80_pkg::byte_t      ir_q;
        // Low operand byte, later replaced by memory read data
        z80_pkg::byte_t      dat_q;
        z80_pkg::byte_t      hi_q;
        logic                bus_state;
        logic                ack_now;
        logic                is_in;
        logic                is_out;
        logic                jp_taken;

        // Operand bytes after the opcode
        function automatic logic [1:0] opnd_cnt(input z80_pkg::byte_t op);
                logic [1:0] cnt;
                cnt = 2'd0;
                if (op == `Z80_OP_JP || op == `Z80_OP_JP_Z || op == `Z80_OP_JP_C ||
                    op == `Z80_OP_LD_NN_A || op == `Z80_OP_LD_A_NN)
                        cnt = 2'd2;
                else if ((op & 8'hC7) == `Z80_OP_LD_R_N || (op & 8'hC7) == `Z80_OP_ADD_N ||
                         op == `Z80_OP_OUT_N_A || op == `Z80_OP_IN_A_N)
                        cnt = 2'd1;
                return cnt;
        endfunction

        // ALU function field, shared by register and immediate forms
        function automatic z80_pkg::alu_op_e alu_sel(input logic [2:0] fn);
                z80_pkg::alu_op_e sel;
                case ({2'b10, fn, 3'b000})
                        `Z80_OP_ADD_R: sel = z80_pkg::ALU_ADD;
                        `Z80_OP_SUB_R: sel = z80_pkg::ALU_SUB;
                        `Z80_OP_AND_R: sel = z80_pkg::ALU_AND;
                        `Z80_OP_XOR_R: sel = z80_pkg::ALU_XOR;
                        `Z80_OP_OR_R:  sel = z80_pkg::ALU_OR;
                        `Z80_OP_CP_R:  sel = z80_pkg::ALU_CP;
                        // ADC and SBC fall out here
                        default:       sel = z80_pkg::ALU_NONE;
                endcase
                return sel;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Opcode decode into an execute operation
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                is_in          = ir_q == `Z80_OP_IN_A_N;
                is_out         = ir_q == `Z80_OP_OUT_N_A;
                op_o.alu_op    = z80_pkg::ALU_NONE;
                op_o.dst       = ir_q[5:3];
                op_o.src       = ir_q[2:0];
                op_o.use_imm   = 1'b0;
                op_o.imm       = dat_q;
                op_o.wr_dst    = 1'b1;
                if ((ir_q & 8'hC7) == `Z80_OP_LD_R_N && ir_q[5:3] != `Z80_REG_HL) begin
                        op_o.alu_op  = z80_pkg::ALU_LOAD;
                        op_o.use_imm = 1'b1;
                end else if ((ir_q & 8'hC0) == `Z80_OP_LD_R_R && ir_q[5:3] != `Z80_REG_HL &&
                             ir_q[2:0] != `Z80_REG_HL) begin
                        op_o.alu_op  = z80_pkg::ALU_LOAD;
                end else if ((ir_q & 8'hC0) == `Z80_OP_ADD_R && ir_q[2:0] != `Z80_REG_HL) begin
                        op_o.alu_op  = alu_sel(ir_q[5:3]);
                        op_o.dst     = `Z80_REG_A;
                end else if ((ir_q & 8'hC7) == `Z80_OP_ADD_N) begin
                        op_o.alu_op  = alu_sel(ir_q[5:3]);
                        op_o.dst     = `Z80_REG_A;
                        op_o.use_imm = 1'b1;
                end else if (ir_q == `Z80_OP_LD_A_NN || is_in) begin
                        op_o.alu_op  = z80_pkg::ALU_LOAD;
                        op_o.dst     = `Z80_REG_A;
                        op_o.use_imm = 1'b1;
                        // Port value arrives through the routed read path
                        if (is_in)
                                op_o.imm = rd_dat_i;
                end
                // Compare only touches the flags
                if (op_o.alu_op == z80_pkg::ALU_CP)
                        op_o.wr_dst = 1'b0;
        end

        assign bus_state = state_q != z80_pkg::ST_ISSUE && state_q != z80_pkg::ST_HALTED;
        assign ack_now   = stb_q && wb_ack_i;
        assign issue_o   = state_q == z80_pkg::ST_ISSUE && op_o.alu_op != z80_pkg::ALU_NONE;
        assign io_rd_o   = state_q == z80_pkg::ST_ISSUE && is_in;
        assign io_wr_o   = state_q == z80_pkg::ST_ISSUE && is_out;
        assign halt_o    = state_q == z80_pkg::ST_HALTED;
        assign jp_taken  = ir_q == `Z80_OP_JP || (ir_q == `Z80_OP_JP_Z && res_i.zf) ||
                           (ir_q == `Z80_OP_JP_C && res_i.cf);

        // Data cycles address {hi, lo}, everything else the PC
        always_comb begin
                bus_o.cyc = stb_q;
                bus_o.stb = stb_q;
                bus_o.we  = state_q == z80_pkg::ST_MEM_WR;
                bus_o.adr = (state_q == z80_pkg::ST_MEM_RD || state_q == z80_pkg::ST_MEM_WR) ?
                            {hi_q, dat_q} : pc_q;
                bus_o.dat = res_i.a_val;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Sequencer
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        state_q <= z80_pkg::ST_FETCH;
                        pc_q    <= `Z80_RESET_PC;
                        stb_q   <= 1'b0;
                end else begin
                        // Strobe up once ack is low, down on the ack
                        if (bus_state && !stb_q && !wb_ack_i)
                                stb_q <= 1'b1;
                        else if (ack_now)
                                stb_q <= 1'b0;
                        case (state_q)
                        z80_pkg::ST_FETCH: if (ack_now) begin
                                pc_q <= pc_q + 16'd1;
                                if (rd_dat_i == `Z80_OP_HALT)
                                        state_q <= z80_pkg::ST_HALTED;
                                else if (opnd_cnt(rd_dat_i) == 2'd0)
                                        state_q <= z80_pkg::ST_ISSUE;
                                else
                                        state_q <= z80_pkg::ST_OPND_LO;
                        end
                        z80_pkg::ST_OPND_LO: if (ack_now) begin
                                pc_q    <= pc_q + 16'd1;
                                state_q <= (opnd_cnt(ir_q) == 2'd2) ? z80_pkg::ST_OPND_HI :
                                                                      z80_pkg::ST_ISSUE;
                        end
                        z80_pkg::ST_OPND_HI: if (ack_now) begin
                                // Jump condition sampled as the high byte lands
                                pc_q <= jp_taken ? {rd_dat_i, dat_q} : pc_q + 16'd1;
                                if (ir_q == `Z80_OP_LD_NN_A)
                                        state_q <= z80_pkg::ST_MEM_WR;
                                else if (ir_q == `Z80_OP_LD_A_NN)
                                        state_q <= z80_pkg::ST_MEM_RD;
                                else
                                        state_q <= z80_pkg::ST_FETCH;
                        end
                        z80_pkg::ST_MEM_WR: if (ack_now)
                                state_q <= z80_pkg::ST_FETCH;
                        z80_pkg::ST_MEM_RD: if (ack_now)
                                state_q <= z80_pkg::ST_ISSUE;
                        z80_pkg::ST_ISSUE:
                                state_q <= z80_pkg::ST_FETCH;
                        // Halted until reset
                        default: ;
                        endcase
                end
        end

        // Captured bytes
        always_ff @(posedge wb_clk_i) begin
                if (ack_now) begin
                        case (state_q)
                        z80_pkg::ST_FETCH:   ir_q  <= rd_dat_i;
                        z80_pkg::ST_OPND_LO: dat_q <= rd_dat_i;
                        z80_pkg::ST_MEM_RD:  dat_q <= rd_dat_i;
                        z80_pkg::ST_OPND_HI: hi_q  <= rd_dat_i;
                        default: ;
                        endcase
                end
        end

        // Every bus cycle is closed before decode leaves the bus states
        assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
                !bus_state |-> !bus_o.stb);

        // Request held steady while the slave is still answering
        assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
                bus_o.stb && !wb_ack_i |=> $stable(bus_o.adr) && $stable(bus_o.we));

endmodule

`default_nettype wire

/* design/z80_pkg.sv */
/* Types shared by decode, execute and the port block.
   Only the Z and C flags exist */
`default_nettype none

package z80_pkg;

        typedef logic [7:0]  byte_t;
        typedef logic [15:0] addr_t;

        // Z80 order, B C D E H L (HL) A
        typedef logic [2:0]  reg_sel_t;

        typedef enum logic [2:0] {
                ALU_NONE,
                ALU_LOAD,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_XOR,
                ALU_OR,
                ALU_CP
        } alu_op_e;

        // Bus phases of one instruction
        typedef enum logic [2:0] {
                ST_FETCH,
                ST_OPND_LO,
                ST_OPND_HI,
                ST_MEM_RD,
                ST_MEM_WR,
                ST_ISSUE,
                ST_HALTED
        } dec_state_e;

        // Decode to execute, valid with the issue pulse
        typedef struct packed {
                alu_op_e  alu_op;
                reg_sel_t dst;
                reg_sel_t src;
                logic     use_imm;
                byte_t    imm;
                logic     wr_dst;
        } exec_op_t;

        // Architectural state seen by decode and the port latch
        typedef struct packed {
                byte_t a_val;
                logic  zf;
                logic  cf;
        } exec_res_t;

        typedef struct packed {
                logic  cyc;
                logic  stb;
                logic  we;
                addr_t adr;
                byte_t dat;
        } bus_req_t;

endpackage

`default_nettype wire

/* design/z80_settings.svh */
/* Opcodes of the kept Z80 subset. Register forms are group bases with the
   r fields at zero. Every other opcode runs as NOP */
`ifndef Z80_SETTINGS_SVH
`define Z80_SETTINGS_SVH

// Program counter after reset
`define Z80_RESET_PC    16'h0000

// Register indices with a special role
`define Z80_REG_HL      3'd6
`define Z80_REG_A       3'd7

`define Z80_OP_NOP      8'h00
`define Z80_OP_HALT     8'h76

// Load groups take dst in bits 5:3 and src in bits 2:0
`define Z80_OP_LD_R_N   8'h06
`define Z80_OP_LD_R_R   8'h40

// ALU against a register
`define Z80_OP_ADD_R    8'h80
`define Z80_OP_SUB_R    8'h90
`define Z80_OP_AND_R    8'hA0
`define Z80_OP_XOR_R    8'hA8
`define Z80_OP_OR_R     8'hB0
`define Z80_OP_CP_R     8'hB8

// ALU against an immediate
`define Z80_OP_ADD_N    8'hC6
`define Z80_OP_SUB_N    8'hD6
`define Z80_OP_AND_N    8'hE6
`define Z80_OP_XOR_N    8'hEE
`define Z80_OP_OR_N     8'hF6
`define Z80_OP_CP_N     8'hFE

// Jumps, memory and port transfers with A
`define Z80_OP_JP       8'hC3
`define Z80_OP_JP_Z     8'hCA
`define Z80_OP_JP_C     8'hDA
`define Z80_OP_LD_NN_A  8'h32
`define Z80_OP_LD_A_NN  8'h3A
`define Z80_OP_OUT_N_A  8'hD3
`define Z80_OP_IN_A_N   8'hDB

`endif
